//--- tb.f
hdl/console_pkg.sv
hdl/word_ram.sv
hdl/flash_access_timer.sv
hdl/flash_port.sv
hdl/dma_fsm.sv
hdl/bus_decoder.sv
hdl/system.sv
sim/flash_model.sv
sim/tb_system.sv

//--- Makefile
SRCS := $(shell cat tb.f)

obj_dir/Vtb_system: tb.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_system -f tb.f -o Vtb_system

run: obj_dir/Vtb_system
	./obj_dir/Vtb_system

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- sim/tb_system.sv
`timescale 1ns/1ps
module tb_system;
	localparam int TIMEOUT = 1000;
	localparam int WORD_CYCLES = console_pkg::FLASH_WAIT_CYCLES + 2;

	logic clk;
	logic arst_n;
	console_pkg::host_req_t host_req;
	logic [15:0] rdata;
	logic rvalid;
	logic proc_en;
	logic dma_done;
	logic [23:0] sf_a;
	wire [15:0] sf_d;
	logic sf_ce0_n;
	logic sf_oe_n;

	integer seed = 32'h70a;
	// expected memory contents, valid where written
	logic [15:0] shadow [console_pkg::RAM_WORDS];

	system system_inst (
		.clk(clk),
		.arst_n(arst_n),
		.host_req(host_req),
		.rdata(rdata),
		.rvalid(rvalid),
		.proc_en(proc_en),
		.dma_done(dma_done),
		.sf_a(sf_a),
		.sf_d(sf_d),
		.sf_ce0_n(sf_ce0_n),
		.sf_oe_n(sf_oe_n)
	);

	flash_model flash_inst (
		.a(sf_a),
		.ce_n(sf_ce0_n),
		.oe_n(sf_oe_n),
		.d(sf_d)
	);

	always #5 clk = ~clk;

	function automatic logic [15:0] flash_word(input logic [22:0] addr);
		return addr[15:0] ^ 16'hA5C3;
	endfunction

	task automatic check_value(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
			$display("Test failures found");
			$fatal(1, "value check failed");
		end
	endtask

	// all bus tasks start and end on a falling edge
	task automatic host_write(input logic [15:0] addr, input logic [15:0] data);
		host_req.valid = 1'b1;
		host_req.write = 1'b1;
		host_req.addr = addr;
		host_req.wdata = data;
		@(negedge clk);
		host_req.valid = 1'b0;
	endtask

	task automatic host_read(input logic [15:0] addr, output logic [15:0] data);
		int cycles;
		host_req.valid = 1'b1;
		host_req.write = 1'b0;
		host_req.addr = addr;
		host_req.wdata = 16'h0000;
		@(negedge clk);
		host_req.valid = 1'b0;
		cycles = 0;
		while (!rvalid) begin
			if (cycles == TIMEOUT) begin
				$display("Timeout waiting for rvalid after a read of address %h", addr);
				$display("Test failures found");
				$fatal(1, "read never answered");
			end
			@(negedge clk);
			cycles++;
		end
		data = rdata;
	endtask

	task automatic expect_read(input logic [15:0] addr, input logic [15:0] expected);
		logic [15:0] data;
		host_read(addr, data);
		check_value($sformatf("rdata[%h]", addr), data, expected);
	endtask

	task automatic start_dma(input logic [22:0] src, input logic [15:0] dst,
			input logic [15:0] len);
		host_write(console_pkg::REG_SRC_LO, src[15:0]);
		host_write(console_pkg::REG_SRC_HI, 16'(src[22:16]));
		host_write(console_pkg::REG_DST, dst);
		host_write(console_pkg::REG_LEN, len);
	endtask

	task automatic wait_dma_done(output int cycles);
		cycles = 0;
		while (!dma_done) begin
			if (cycles == TIMEOUT) begin
				$display("Timeout waiting for dma_done");
				$display("Test failures found");
				$fatal(1, "transfer never finished");
			end
			@(negedge clk);
			cycles++;
		end
		check_value("proc_en", proc_en, 1'b1);
		@(negedge clk);
		// single-cycle strobe
		check_value("dma_done", dma_done, 1'b0);
	endtask

	task automatic fill_memory(input int first, input int count);
		logic [15:0] data;
		for (int i = 0; i < count; i++) begin
			data = 16'($random(seed));
			shadow[(first + i) % console_pkg::RAM_WORDS] = data;
			host_write(16'((first + i) % console_pkg::RAM_WORDS), data);
		end
	endtask

	task automatic check_memory(input int first, input int count);
		for (int i = 0; i < count; i++) begin
			expect_read(16'((first + i) % console_pkg::RAM_WORDS),
				shadow[(first + i) % console_pkg::RAM_WORDS]);
		end
	endtask

	task automatic check_copy(input logic [22:0] src, input int dst, input int len);
		for (int i = 0; i < len; i++) begin
			shadow[(dst + i) % console_pkg::RAM_WORDS] = flash_word(src + 23'(i));
		end
		check_memory(dst, len);
	endtask

	task automatic reset_state();
		check_value("proc_en", proc_en, 1'b1);
		check_value("dma_done", dma_done, 1'b0);
		check_value("rvalid", rvalid, 1'b0);
		check_value("sf_ce0_n", sf_ce0_n, 1'b1);
		check_value("sf_oe_n", sf_oe_n, 1'b1);
		expect_read(console_pkg::REG_STATUS, 16'h0000);
	endtask

	task automatic host_memory_rw();
		fill_memory(40, 16);
		check_memory(40, 16);
	endtask

	task automatic copy_eight_words();
		logic [22:0] src;
		logic [23:0] last_addr;
		int cycles;
		int reads_before;
		src = 23'($random(seed));
		fill_memory(12, 16);
		reads_before = flash_inst.reads;
		start_dma(src, 16'd16, 16'd8);
		wait_dma_done(cycles);
		check_value("transfer cycles", 16'(cycles), 16'(8 * WORD_CYCLES));
		check_value("flash reads", 16'(flash_inst.reads - reads_before), 16'd8);
		// address pins hold the last word, strobes released
		last_addr = {1'b0, src + 23'd7};
		check_value("sf_a[15:0]", sf_a[15:0], last_addr[15:0]);
		check_value("sf_a[23:16]", 16'(sf_a[23:16]), 16'(last_addr[23:16]));
		check_value("sf_ce0_n", sf_ce0_n, 1'b1);
		check_value("sf_oe_n", sf_oe_n, 1'b1);
		check_copy(src, 16, 8);
		// neighbors below and above the copied block
		check_memory(12, 4);
		check_memory(24, 4);
	endtask

	task automatic access_while_busy();
		logic [22:0] src;
		int cycles;
		src = 23'($random(seed));
		fill_memory(300, 1);
		start_dma(src, 16'd200, 16'd8);
		check_value("proc_en", proc_en, 1'b0);
		expect_read(console_pkg::REG_STATUS, 16'h0001);
		host_write(16'd300, ~shadow[300]);
		expect_read(16'd300, 16'h0000);
		wait_dma_done(cycles);
		expect_read(console_pkg::REG_STATUS, 16'h0000);
		check_memory(300, 1);
		check_copy(src, 200, 8);
	endtask

	task automatic wrap_and_empty();
		logic [22:0] src;
		int cycles;
		int reads_before;
		src = 23'($random(seed));
		fill_memory(1019, 11);
		start_dma(src, 16'd1020, 16'd8);
		wait_dma_done(cycles);
		check_copy(src, 1020, 8);
		check_memory(1019, 1);
		check_memory(4, 2);

		// zero length, done right after start
		fill_memory(500, 4);
		reads_before = flash_inst.reads;
		start_dma(23'($random(seed)), 16'd500, 16'd0);
		wait_dma_done(cycles);
		check_value("transfer cycles", 16'(cycles), 16'd0);
		check_value("flash reads", 16'(flash_inst.reads - reads_before), 16'd0);
		check_memory(500, 4);
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		host_req = '0;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		reset_state();
		host_memory_rw();
		copy_eight_words();
		access_while_busy();
		wrap_and_empty();
		$display("All tests passed!");
		$finish;
	end
endmodule

//--- sim/flash_model.sv
`timescale 1ns/1ps
module flash_model (
	input  logic [23:0] a,
	input  logic ce_n,
	input  logic oe_n,
	output logic [15:0] d
);
	// number of read cycles started, one per rise of the output window
	int reads = 0;
	logic active;

	// high only while both strobes are low
	assign active = !ce_n && !oe_n;

	// data is a fixed pattern of the word address
	assign d = active ? (a[15:0] ^ 16'hA5C3) : 16'hxxxx;

	always @(posedge active) begin
		reads++;
	end
endmodule

//--- hdl/system.sv
`timescale 1ns/1ps
module system (
	input  logic clk,
	input  logic arst_n,
	// host bus
	input  console_pkg::host_req_t host_req,
	output logic [15:0] rdata,
	output logic rvalid,
	output logic proc_en,
	output logic dma_done,
	// StrataFlash
	output logic [23:0] sf_a,
	input  logic [15:0] sf_d,
	output logic sf_ce0_n,
	output logic sf_oe_n
);
	logic busy;
	logic start;
	console_pkg::dma_cfg_t cfg;

	// memory port
	console_pkg::ram_req_t dma_ram;
	console_pkg::ram_req_t ram_req;
	logic [15:0] ram_rdata;

	// flash side
	logic timer_start;
	logic timer_done;
	logic [console_pkg::FLASH_AW-1:0] flash_addr;
	logic [console_pkg::FLASH_AW-1:0] flash_pins;
	logic [15:0] rd_data;

	bus_decoder decoder (
		.clk(clk),
		.arst_n(arst_n),
		.host_req(host_req),
		.busy(busy),
		.dma_ram(dma_ram),
		.ram_rdata(ram_rdata),
		.ram_req(ram_req),
		.start(start),
		.cfg(cfg),
		.rdata(rdata),
		.rvalid(rvalid)
	);

	dma_fsm dma_controller (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.cfg(cfg),
		.rd_data(rd_data),
		.timer_done(timer_done),
		.timer_start(timer_start),
		.flash_addr(flash_addr),
		.dma_ram(dma_ram),
		.busy(busy),
		.dma_done(dma_done)
	);

	flash_access_timer flash_timer (
		.clk(clk),
		.arst_n(arst_n),
		.start(timer_start),
		.done(timer_done)
	);

	flash_port flash (
		.clk(clk),
		.arst_n(arst_n),
		.start(timer_start),
		.addr(flash_addr),
		.timer_done(timer_done),
		.sf_a(flash_pins),
		.sf_d(sf_d),
		.sf_ce0_n(sf_ce0_n),
		.sf_oe_n(sf_oe_n),
		.rd_data(rd_data)
	);

	word_ram ram (
		.clk(clk),
		.req(ram_req),
		.rdata(ram_rdata)
	);

	// top address bit selects the upper flash die, never used here
	assign sf_a = {1'b0, flash_pins};

	// processor stalls for the whole copy
	assign proc_en = !busy;
endmodule

//--- hdl/bus_decoder.sv
`timescale 1ns/1ps
module bus_decoder (
	input  logic clk,
	input  logic arst_n,
	input  console_pkg::host_req_t host_req,
	input  logic busy,
	input  console_pkg::ram_req_t dma_ram,
	input  logic [15:0] ram_rdata,
	output console_pkg::ram_req_t ram_req,
	output logic start,
	output console_pkg::dma_cfg_t cfg,
	output logic [15:0] rdata,
	output logic rvalid
);
	logic [console_pkg::FLASH_AW-1:0] src_q;
	logic [console_pkg::RAM_AW-1:0] dst_q;
	logic [console_pkg::LEN_W-1:0] len_q;

	logic is_ram;
	logic reg_wr;
	logic host_rd;
	logic [15:0] reg_val;
	console_pkg::ram_req_t host_ram;

	// read return path
	logic rd_ram_q;
	logic [15:0] rd_val_q;

	assign is_ram = host_req.addr[15:console_pkg::RAM_AW] == '0;
	assign reg_wr = host_req.valid && host_req.write && !busy;
	assign host_rd = host_req.valid && !host_req.write;

	// len comes straight off the bus so the engine starts right away
	assign start = reg_wr && host_req.addr == console_pkg::REG_LEN;

	always_comb begin
		cfg.src = src_q;
		cfg.dst = dst_q;
		cfg.len = host_req.wdata[console_pkg::LEN_W-1:0];
	end

	always_comb begin
		host_ram.en = host_req.valid && is_ram;
		host_ram.write = host_req.write;
		host_ram.addr = host_req.addr[console_pkg::RAM_AW-1:0];
		host_ram.wdata = host_req.wdata;
	end

	// DMA owns the memory while busy
	assign ram_req = busy ? dma_ram : host_ram;

	always_comb begin
		case (host_req.addr)
			console_pkg::REG_SRC_LO: reg_val = src_q[15:0];
			console_pkg::REG_SRC_HI: reg_val = 16'(src_q[console_pkg::FLASH_AW-1:16]);
			console_pkg::REG_DST: reg_val = 16'(dst_q);
			console_pkg::REG_LEN: reg_val = 16'(len_q);
			console_pkg::REG_STATUS: reg_val = 16'(busy);
			default: reg_val = 16'h0000;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			src_q <= '0;
			dst_q <= '0;
			len_q <= '0;
		end else if (reg_wr) begin
			case (host_req.addr)
				console_pkg::REG_SRC_LO: src_q[15:0] <= host_req.wdata;
				console_pkg::REG_SRC_HI: begin
					src_q[console_pkg::FLASH_AW-1:16] <=
						host_req.wdata[console_pkg::FLASH_AW-17:0];
				end
				console_pkg::REG_DST: dst_q <= host_req.wdata[console_pkg::RAM_AW-1:0];
				console_pkg::REG_LEN: len_q <= host_req.wdata[console_pkg::LEN_W-1:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
			rd_ram_q <= 1'b0;
		end else begin
			rvalid <= host_rd;
			rd_ram_q <= host_rd && is_ram && !busy;
		end
	end

	// memory reads and unmapped addresses return zero from here
	always_ff @(posedge clk) begin
		rd_val_q <= is_ram ? 16'h0000 : reg_val;
	end

	assign rdata = rd_ram_q ? ram_rdata : rd_val_q;
endmodule

//--- hdl/dma_fsm.sv
`timescale 1ns/1ps
module dma_fsm (
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  console_pkg::dma_cfg_t cfg,
	input  logic [15:0] rd_data,
	input  logic timer_done,
	output logic timer_start,
	output logic [console_pkg::FLASH_AW-1:0] flash_addr,
	output console_pkg::ram_req_t dma_ram,
	output logic busy,
	output logic dma_done
);
	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE
	} state_t;

	state_t state;

	logic [console_pkg::FLASH_AW-1:0] src_q;
	logic [console_pkg::RAM_AW-1:0] dst_q;
	logic [console_pkg::LEN_W-1:0] remain;
	logic last_word;

	assign last_word = remain == console_pkg::LEN_W'(1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			src_q <= '0;
			dst_q <= '0;
			remain <= '0;
			timer_start <= 1'b0;
			dma_done <= 1'b0;
		end else begin
			timer_start <= 1'b0;
			dma_done <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						src_q <= cfg.src;
						dst_q <= cfg.dst;
						remain <= cfg.len;
						if (cfg.len == '0) begin
							// nothing to copy
							dma_done <= 1'b1;
						end else begin
							state <= READ;
							timer_start <= 1'b1;
						end
					end
				end
				READ: begin
					// flash port latches the word on the same edge
					if (timer_done) begin
						state <= WRITE;
					end
				end
				WRITE: begin
					src_q <= src_q + 1'b1;
					// wraps at the top of memory
					dst_q <= dst_q + 1'b1;
					remain <= remain - 1'b1;
					if (last_word) begin
						state <= IDLE;
						dma_done <= 1'b1;
					end else begin
						state <= READ;
						timer_start <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign busy = state != IDLE;
	assign flash_addr = src_q;

	always_comb begin
		dma_ram.en = state == WRITE;
		dma_ram.write = 1'b1;
		dma_ram.addr = dst_q;
		dma_ram.wdata = rd_data;
	end
endmodule

//--- hdl/flash_port.sv
`timescale 1ns/1ps
module flash_port (
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  logic [console_pkg::FLASH_AW-1:0] addr,
	input  logic timer_done,
	output logic [console_pkg::FLASH_AW-1:0] sf_a,
	input  logic [15:0] sf_d,
	output logic sf_ce0_n,
	output logic sf_oe_n,
	output logic [15:0] rd_data
);
	// pins come straight from flops
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sf_a <= '0;
			sf_ce0_n <= 1'b1;
			sf_oe_n <= 1'b1;
		end else if (start) begin
			sf_a <= addr;
			sf_ce0_n <= 1'b0;
			sf_oe_n <= 1'b0;
		end else if (timer_done) begin
			sf_ce0_n <= 1'b1;
			sf_oe_n <= 1'b1;
		end
	end

	// data is stable by the end of the wait window
	always_ff @(posedge clk) begin
		if (timer_done) begin
			rd_data <= sf_d;
		end
	end
endmodule

//--- hdl/flash_access_timer.sv
`timescale 1ns/1ps
module flash_access_timer (
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	output logic done
);
	// zero means idle
	logic [console_pkg::TIMER_W-1:0] count;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (start) begin
			count <= console_pkg::TIMER_W'(console_pkg::FLASH_WAIT_CYCLES);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// last wait cycle, counter hits zero on this edge
	assign done = count == console_pkg::TIMER_W'(1);
endmodule

//--- hdl/word_ram.sv
`timescale 1ns/1ps
module word_ram (
	input  logic clk,
	input  console_pkg::ram_req_t req,
	output logic [15:0] rdata
);
	logic [15:0] mem [console_pkg::RAM_WORDS];

	always_ff @(posedge clk) begin
		if (req.en) begin
			if (req.write) begin
				mem[req.addr] <= req.wdata;
			end
			// old data on a write cycle, nobody reads it then
			rdata <= mem[req.addr];
		end
	end
endmodule

//--- hdl/console_pkg.sv
package console_pkg;

	// work memory geometry
	localparam int RAM_WORDS = 1024;
	localparam int RAM_AW = 10;

	// parallel flash, word addressed
	localparam int FLASH_AW = 23;
	localparam int FLASH_WAIT_CYCLES = 4;
	localparam int TIMER_W = $clog2(FLASH_WAIT_CYCLES + 1);

	// transfer length, enough for a full memory image
	localparam int LEN_W = 11;

	// DMA register map
	localparam logic [15:0] REG_SRC_LO = 16'h8000;
	localparam logic [15:0] REG_SRC_HI = 16'h8001;
	localparam logic [15:0] REG_DST = 16'h8002;
	localparam logic [15:0] REG_LEN = 16'h8003;
	localparam logic [15:0] REG_STATUS = 16'h8004;

	typedef struct packed {
		logic valid;
		logic write;
		logic [15:0] addr;
		logic [15:0] wdata;
	} host_req_t;

	typedef struct packed {
		logic en;
		logic write;
		logic [RAM_AW-1:0] addr;
		logic [15:0] wdata;
	} ram_req_t;

	typedef struct packed {
		logic [FLASH_AW-1:0] src;
		logic [RAM_AW-1:0] dst;
		logic [LEN_W-1:0] len;
	} dma_cfg_t;

endpackage
